// ==== source/hdc_macros.svh ====
`ifndef HDC_MACROS_SVH
`define HDC_MACROS_SVH

// hypervector width in bits
`define HDC_DIM 256

// item memory depth and address width
`define HDC_DEPTH 1024
`define HDC_ADDR_W 10

// signed width of each per-bit bundle counter
`define HDC_CNT_W 6

// replicated across the full LFSR width at reset
`define HDC_LFSR_SEED 32'hA5C3_1E97

`endif

// ==== source/hdc_data_pkg.sv ====
`include "hdc_macros.svh"

package hdc_data_pkg;

    // one hypervector, the payload of every datapath
    typedef logic [`HDC_DIM-1:0] hvec_t;

    // index into the item memory
    typedef logic [`HDC_ADDR_W-1:0] item_addr_t;

    // per-bit majority counter, two's complement
    typedef logic signed [`HDC_CNT_W-1:0] bundle_cnt_t;

endpackage

// ==== source/hdc_isa_pkg.sv ====
package hdc_isa_pkg;

    typedef logic [15:0] inst_t;

    // set when the word carries a memory address
    localparam int bit_addr = 15;

    // flags of the address group
    localparam int bit_load    = 14;
    localparam int bit_lrshift = 13;
    localparam int bit_llshift = 12;
    localparam int bit_lxor    = 11;
    // with bit_addr this marks wb.item
    localparam int bit_wb_item = 10;

    // flags of the register group
    localparam int bit_rshift = 14;
    localparam int bit_lshift = 13;
    localparam int bit_xor    = 12;
    localparam int bit_store  = 11;
    localparam int bit_last   = 10;
    localparam int bit_move   = 9;
    localparam int bit_wb     = 8;

    // address field
    localparam int addr_msb = 9;
    localparam int addr_lsb = 0;

    // address opcodes get the item address added in
    localparam inst_t op_nop     = 16'h0000;
    localparam inst_t op_load    = 16'hC000;
    localparam inst_t op_lrshift = 16'hA000;
    localparam inst_t op_llshift = 16'h9000;
    localparam inst_t op_lxor    = 16'h8800;
    localparam inst_t op_rshift  = 16'h4000;
    localparam inst_t op_lshift  = 16'h2000;
    localparam inst_t op_xor     = 16'h1000;
    localparam inst_t op_store   = 16'h0800;
    localparam inst_t op_last    = 16'h0400;
    localparam inst_t op_move    = 16'h0200;
    localparam inst_t op_wb      = 16'h0100;
    localparam inst_t op_wb_item = 16'h8400;

endpackage

// ==== source/hdc_item_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_macros.svh"

module hdc_item_memory (
    input  wire logic                     clk,
    input  wire logic                     wr_en,
    input  wire hdc_data_pkg::item_addr_t wr_addr,
    input  wire hdc_data_pkg::hvec_t      wr_data,
    input  wire hdc_data_pkg::item_addr_t rd_addr,
    output hdc_data_pkg::hvec_t           rd_data
);

    // block ram array of item hypervectors
    hdc_data_pkg::hvec_t mem [`HDC_DEPTH];

    // single write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read streams every cycle, consumer decides whether to use it
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== source/hdc_item_lfsr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_macros.svh"

module hdc_item_lfsr (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                step,
    output hdc_data_pkg::hvec_t      rand_vec
);

    localparam int dim = `HDC_DIM;

    hdc_data_pkg::hvec_t lfsr;
    logic                fb;

    // fibonacci taps at the top, dim-3, dim-5 and dim-10
    assign fb = lfsr[dim-1] ^ lfsr[dim-3] ^ lfsr[dim-5] ^ lfsr[dim-10];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= {(dim / 32){`HDC_LFSR_SEED}};
        end else if (step) begin
            lfsr <= {lfsr[dim-2:0], fb};
        end
    end

    // current state is the vector written by this generate
    assign rand_vec = lfsr;

endmodule

`default_nettype wire

// ==== source/hdc_inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module hdc_inst_decode (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     get_v,
    input  wire hdc_isa_pkg::inst_t       get_d,
    output hdc_isa_pkg::inst_t            inst,
    output logic                          wb_flag,
    output hdc_data_pkg::item_addr_t      wb_addr
);

    logic is_wb_item;

    // wb.item is the only address word with bit 10 set
    assign is_wb_item = get_d[hdc_isa_pkg::bit_addr] & get_d[hdc_isa_pkg::bit_wb_item];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst    <= hdc_isa_pkg::op_nop;
            wb_flag <= 1'b0;
            wb_addr <= '0;
        end else if (get_v) begin
            if (is_wb_item) begin
                // handled by the memory write port, alu sees a nop
                inst    <= hdc_isa_pkg::op_nop;
                wb_flag <= 1'b1;
                wb_addr <= get_d[hdc_isa_pkg::addr_msb:hdc_isa_pkg::addr_lsb];
            end else begin
                inst    <= get_d;
                wb_flag <= 1'b0;
                wb_addr <= '0;
            end
        end else begin
            // nothing received, drop back to idle
            // exec still sees the word registered one edge earlier
            inst    <= hdc_isa_pkg::op_nop;
            wb_flag <= 1'b0;
            wb_addr <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/hdc_vector_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_macros.svh"

module hdc_vector_alu (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                run,
    input  wire logic                exec,
    input  wire hdc_isa_pkg::inst_t  inst,
    input  wire hdc_data_pkg::hvec_t load_vec,
    input  wire hdc_data_pkg::hvec_t sign_vec,
    output hdc_data_pkg::hvec_t      acc_vec,
    output logic                     store,
    output hdc_data_pkg::hvec_t      core_result,
    output logic                     last
);

    localparam int dim = `HDC_DIM;

    hdc_data_pkg::hvec_t reg_1;
    hdc_data_pkg::hvec_t reg_2;
    hdc_data_pkg::hvec_t buff;

    logic do_load;
    logic do_lrshift;
    logic do_llshift;
    logic do_lxor;
    logic do_rshift;
    logic do_lshift;
    logic do_xor;
    logic do_store;
    logic do_last;
    logic do_move;
    logic do_wb;

    // priority decode, highest flag wins inside each group
    always_comb begin
        do_load    = 1'b0;
        do_lrshift = 1'b0;
        do_llshift = 1'b0;
        do_lxor    = 1'b0;
        do_rshift  = 1'b0;
        do_lshift  = 1'b0;
        do_xor     = 1'b0;
        do_store   = 1'b0;
        do_last    = 1'b0;
        do_move    = 1'b0;
        do_wb      = 1'b0;
        if (inst[hdc_isa_pkg::bit_addr]) begin
            if (inst[hdc_isa_pkg::bit_load])         do_load    = 1'b1;
            else if (inst[hdc_isa_pkg::bit_lrshift]) do_lrshift = 1'b1;
            else if (inst[hdc_isa_pkg::bit_llshift]) do_llshift = 1'b1;
            else if (inst[hdc_isa_pkg::bit_lxor])    do_lxor    = 1'b1;
        end else begin
            if (inst[hdc_isa_pkg::bit_rshift])      do_rshift = 1'b1;
            else if (inst[hdc_isa_pkg::bit_lshift]) do_lshift = 1'b1;
            else if (inst[hdc_isa_pkg::bit_xor])    do_xor    = 1'b1;
            else if (inst[hdc_isa_pkg::bit_store])  do_store  = 1'b1;
            else if (inst[hdc_isa_pkg::bit_last])   do_last   = 1'b1;
            else if (inst[hdc_isa_pkg::bit_move])   do_move   = 1'b1;
            else if (inst[hdc_isa_pkg::bit_wb])     do_wb     = 1'b1;
        end
    end

    // registers keep their values between instructions, run low clears them
    always_ff @(posedge clk) begin
        if (!run) begin
            reg_1 <= '0;
            reg_2 <= '0;
            buff  <= '0;
        end else if (exec) begin
            // both shifts rotate by one bit
            if (do_load)         reg_2 <= load_vec;
            else if (do_lrshift) reg_2 <= {load_vec[0], load_vec[dim-1:1]};
            else if (do_llshift) reg_2 <= {load_vec[dim-2:0], load_vec[dim-1]};
            else if (do_lxor)    reg_2 <= load_vec ^ reg_2;
            else if (do_rshift)  reg_2 <= {reg_2[0], reg_2[dim-1:1]};
            else if (do_lshift)  reg_2 <= {reg_2[dim-2:0], reg_2[dim-1]};
            else if (do_xor)     reg_2 <= reg_1 ^ reg_2;
            else if (do_wb)      reg_2 <= sign_vec;
            if (do_move) begin
                reg_1 <= reg_2;
            end
            if (do_store) begin
                buff <= reg_2;
            end
        end
    end

    // one-cycle strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            store <= 1'b0;
            last  <= 1'b0;
        end else if (!run) begin
            store <= 1'b0;
            last  <= 1'b0;
        end else begin
            store <= exec & do_store;
            last  <= exec & do_last;
        end
    end

    assign acc_vec = reg_2;

    // result port is quiet outside the store strobe
    assign core_result = store ? buff : '0;

endmodule

`default_nettype wire

// ==== source/hdc_bundler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hdc_macros.svh"

module hdc_bundler (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                run,
    input  wire logic                add,
    input  wire hdc_data_pkg::hvec_t vec,
    output hdc_data_pkg::hvec_t      sign_vec
);

    localparam int dim   = `HDC_DIM;
    localparam int cnt_w = `HDC_CNT_W;

    // signed limits of one counter
    localparam hdc_data_pkg::bundle_cnt_t cnt_max = {1'b0, {(cnt_w - 1){1'b1}}};
    localparam hdc_data_pkg::bundle_cnt_t cnt_min = {1'b1, {(cnt_w - 1){1'b0}}};

    hdc_data_pkg::bundle_cnt_t cnt [dim];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < dim; i++) begin
                cnt[i] <= '0;
            end
        end else if (!run) begin
            for (int i = 0; i < dim; i++) begin
                cnt[i] <= '0;
            end
        end else if (add) begin
            for (int i = 0; i < dim; i++) begin
                // up on a one, down on a zero, stick at the limits
                if (vec[i]) begin
                    if (cnt[i] != cnt_max) begin
                        cnt[i] <= cnt[i] + 2'sd1;
                    end
                end else begin
                    if (cnt[i] != cnt_min) begin
                        cnt[i] <= cnt[i] - 2'sd1;
                    end
                end
            end
        end
    end

    // majority bit with ties counted as zero
    always_comb begin
        for (int i = 0; i < dim; i++) begin
            sign_vec[i] = (cnt[i] > 0);
        end
    end

endmodule

`default_nettype wire

// ==== source/hdc_accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hdc_accel_top (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     run,
    input  wire logic                     gen,
    input  wire logic                     update_item,
    input  wire hdc_data_pkg::item_addr_t item_a,
    input  wire logic                     get_v,
    input  wire hdc_isa_pkg::inst_t       get_d,
    input  wire logic                     exec,
    output logic                          store,
    output hdc_data_pkg::hvec_t           core_result,
    output logic                          last
);

    hdc_data_pkg::hvec_t      rand_vec;
    hdc_data_pkg::hvec_t      load_vec;
    hdc_data_pkg::hvec_t      acc_vec;
    hdc_data_pkg::hvec_t      sign_vec;
    hdc_isa_pkg::inst_t       inst;
    logic                     wb_flag;
    hdc_data_pkg::item_addr_t wb_addr;

    logic                     gen_wr;
    logic                     mem_wr_en;
    hdc_data_pkg::item_addr_t mem_wr_addr;
    hdc_data_pkg::hvec_t      mem_wr_data;

    // write-back wins, a colliding generate is dropped
    assign gen_wr      = gen & update_item & ~wb_flag;
    assign mem_wr_en   = wb_flag | gen_wr;
    assign mem_wr_addr = wb_flag ? wb_addr : item_a;
    assign mem_wr_data = wb_flag ? acc_vec : rand_vec;

    hdc_item_lfsr u_hdc_item_lfsr (
        .clk      (clk),
        .arst_n   (arst_n),
        .step     (gen_wr),
        .rand_vec (rand_vec)
    );

    hdc_item_memory u_hdc_item_memory (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd_addr (get_d[hdc_isa_pkg::addr_msb:hdc_isa_pkg::addr_lsb]),
        .rd_data (load_vec)
    );

    hdc_inst_decode u_hdc_inst_decode (
        .clk     (clk),
        .arst_n  (arst_n),
        .get_v   (get_v),
        .get_d   (get_d),
        .inst    (inst),
        .wb_flag (wb_flag),
        .wb_addr (wb_addr)
    );

    hdc_vector_alu u_hdc_vector_alu (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .exec        (exec),
        .inst        (inst),
        .load_vec    (load_vec),
        .sign_vec    (sign_vec),
        .acc_vec     (acc_vec),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

    hdc_bundler u_hdc_bundler (
        .clk      (clk),
        .arst_n   (arst_n),
        .run      (run),
        .add      (store),
        .vec      (core_result),
        .sign_vec (sign_vec)
    );

endmodule

`default_nettype wire

// ==== tb/hdc_accel_tb.sv ====
`timescale 1ns/1ps

`include "hdc_macros.svh"

module hdc_accel_tb;

    localparam int dim          = `HDC_DIM;
    localparam int reset_cycles = 16;
    localparam int n_tests      = 6;
    localparam int n_steps      = 51;
    localparam int cycle_limit  = 2 * n_steps + reset_cycles + 100;
    localparam int cnt_max      = (1 << (`HDC_CNT_W - 1)) - 1;
    localparam int cnt_min      = -(1 << (`HDC_CNT_W - 1));

    // kinds of program step
    localparam logic [3:0] k_gen  = 4'd0;
    localparam logic [3:0] k_inst = 4'd1;
    localparam logic [3:0] k_idle = 4'd2;
    localparam logic [3:0] k_drop = 4'd3;

    // test id, step kind, instruction word or item address
    localparam logic [23:0] prog [n_steps] = '{
        // generate at four addresses, then load and store each
        {4'd1, k_gen, 16'd3}, {4'd1, k_gen, 16'd17}, {4'd1, k_gen, 16'd100},
        {4'd1, k_gen, 16'd513},
        {4'd1, k_inst, hdc_isa_pkg::op_load + 16'd3}, {4'd1, k_inst, hdc_isa_pkg::op_store},
        {4'd1, k_inst, hdc_isa_pkg::op_load + 16'd17}, {4'd1, k_inst, hdc_isa_pkg::op_store},
        {4'd1, k_inst, hdc_isa_pkg::op_load + 16'd100},
        {4'd1, k_inst, hdc_isa_pkg::op_store},
        {4'd1, k_inst, hdc_isa_pkg::op_load + 16'd513},
        {4'd1, k_inst, hdc_isa_pkg::op_store},
        // rotations of a memory operand and of reg_2
        {4'd2, k_inst, hdc_isa_pkg::op_lrshift + 16'd17},
        {4'd2, k_inst, hdc_isa_pkg::op_store},
        {4'd2, k_inst, hdc_isa_pkg::op_llshift + 16'd100},
        {4'd2, k_inst, hdc_isa_pkg::op_store},
        {4'd2, k_inst, hdc_isa_pkg::op_rshift}, {4'd2, k_inst, hdc_isa_pkg::op_store},
        {4'd2, k_inst, hdc_isa_pkg::op_lshift}, {4'd2, k_inst, hdc_isa_pkg::op_store},
        // l.xor, move, xor
        {4'd3, k_inst, hdc_isa_pkg::op_load + 16'd3}, {4'd3, k_inst, hdc_isa_pkg::op_lxor + 16'd17},
        {4'd3, k_inst, hdc_isa_pkg::op_store}, {4'd3, k_inst, hdc_isa_pkg::op_move},
        {4'd3, k_inst, hdc_isa_pkg::op_load + 16'd100}, {4'd3, k_inst, hdc_isa_pkg::op_xor},
        {4'd3, k_inst, hdc_isa_pkg::op_store},
        // fresh counters, three stores, then the majority through wb
        {4'd4, k_idle, 16'd0}, {4'd4, k_drop, 16'd0},
        {4'd4, k_inst, hdc_isa_pkg::op_load + 16'd3}, {4'd4, k_inst, hdc_isa_pkg::op_store},
        {4'd4, k_inst, hdc_isa_pkg::op_load + 16'd17}, {4'd4, k_inst, hdc_isa_pkg::op_store},
        {4'd4, k_inst, hdc_isa_pkg::op_load + 16'd513}, {4'd4, k_inst, hdc_isa_pkg::op_store},
        {4'd4, k_idle, 16'd0}, {4'd4, k_inst, hdc_isa_pkg::op_wb},
        {4'd4, k_inst, hdc_isa_pkg::op_store},
        // reg_2 written back to a new item, then read again
        {4'd5, k_inst, hdc_isa_pkg::op_load + 16'd513}, {4'd5, k_inst, hdc_isa_pkg::op_lxor + 16'd3},
        {4'd5, k_inst, hdc_isa_pkg::op_wb_item + 16'd700},
        {4'd5, k_inst, hdc_isa_pkg::op_load + 16'd17},
        {4'd5, k_inst, hdc_isa_pkg::op_load + 16'd700}, {4'd5, k_inst, hdc_isa_pkg::op_store},
        // last strobe, then a soft clear
        {4'd6, k_inst, hdc_isa_pkg::op_last}, {4'd6, k_idle, 16'd0}, {4'd6, k_drop, 16'd0},
        {4'd6, k_inst, hdc_isa_pkg::op_store}, {4'd6, k_idle, 16'd0},
        {4'd6, k_inst, hdc_isa_pkg::op_wb}, {4'd6, k_inst, hdc_isa_pkg::op_store}
    };

    logic                     clk = 1'b0;
    logic                     arst_n;
    logic                     run;
    logic                     gen;
    logic                     update_item;
    hdc_data_pkg::item_addr_t item_a;
    logic                     get_v;
    hdc_isa_pkg::inst_t       get_d;
    logic                     exec;
    logic                     store;
    hdc_data_pkg::hvec_t      core_result;
    logic                     last;

    // expected outputs, indexed by loop cycle
    bit                  exp_store [n_steps + 2];
    bit                  exp_last [n_steps + 2];
    hdc_data_pkg::hvec_t exp_val [n_steps + 2];

    // reference model state
    hdc_data_pkg::hvec_t m_mem [`HDC_DEPTH];
    hdc_data_pkg::hvec_t m_lfsr;
    hdc_data_pkg::hvec_t m_reg_1;
    hdc_data_pkg::hvec_t m_reg_2;
    hdc_data_pkg::hvec_t m_buff;
    int                  m_cnt [dim];

    int test_errs [n_tests + 1];
    int total_errs = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycles = 0;

    hdc_accel_top u_hdc_accel_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .gen         (gen),
        .update_item (update_item),
        .item_a      (item_a),
        .get_v       (get_v),
        .get_d       (get_d),
        .exec        (exec),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // applies one program step to the model, results land two cycles later
    task automatic model_step(input int k);
        logic [3:0]               kind;
        hdc_isa_pkg::inst_t       w;
        hdc_data_pkg::item_addr_t a;
        logic                     fb;
        kind = prog[k][19:16];
        w    = prog[k][15:0];
        a    = w[9:0];
        if (kind == k_gen) begin
            // current state goes to memory, then one lfsr step
            m_mem[a] = m_lfsr;
            fb = m_lfsr[dim-1] ^ m_lfsr[dim-3] ^ m_lfsr[dim-5] ^ m_lfsr[dim-10];
            m_lfsr = {m_lfsr[dim-2:0], fb};
        end else if (kind == k_drop) begin
            m_reg_1 = '0;
            m_reg_2 = '0;
            m_buff  = '0;
            m_cnt   = '{default: 0};
        end else if (kind == k_inst && w[15]) begin
            case (w & 16'hFC00)
                hdc_isa_pkg::op_load:    m_reg_2 = m_mem[a];
                hdc_isa_pkg::op_lrshift: m_reg_2 = {m_mem[a][0], m_mem[a][dim-1:1]};
                hdc_isa_pkg::op_llshift: m_reg_2 = {m_mem[a][dim-2:0], m_mem[a][dim-1]};
                hdc_isa_pkg::op_lxor:    m_reg_2 = m_mem[a] ^ m_reg_2;
                hdc_isa_pkg::op_wb_item: m_mem[a] = m_reg_2;
                default: ;
            endcase
        end else if (kind == k_inst) begin
            case (w)
                hdc_isa_pkg::op_rshift: m_reg_2 = {m_reg_2[0], m_reg_2[dim-1:1]};
                hdc_isa_pkg::op_lshift: m_reg_2 = {m_reg_2[dim-2:0], m_reg_2[dim-1]};
                hdc_isa_pkg::op_xor:    m_reg_2 = m_reg_1 ^ m_reg_2;
                hdc_isa_pkg::op_move:   m_reg_1 = m_reg_2;
                hdc_isa_pkg::op_last:   exp_last[k + 2] = 1'b1;
                hdc_isa_pkg::op_store: begin
                    m_buff = m_reg_2;
                    exp_store[k + 2] = 1'b1;
                    exp_val[k + 2] = m_buff;
                    // saturating up/down count per bit
                    for (int i = 0; i < dim; i++) begin
                        if (m_buff[i] && m_cnt[i] < cnt_max) m_cnt[i]++;
                        else if (!m_buff[i] && m_cnt[i] > cnt_min) m_cnt[i]--;
                    end
                end
                hdc_isa_pkg::op_wb: begin
                    for (int i = 0; i < dim; i++) begin
                        m_reg_2[i] = (m_cnt[i] > 0);
                    end
                end
                default: ;
            endcase
        end
    endtask

    task automatic count_error(input int t);
        test_errs[t]++;
        total_errs++;
    endtask

    task automatic check_outputs(input int c);
        int t;
        t = (c >= 2) ? int'(prog[c - 2][23:20]) : 1;
        assert (store === exp_store[c]) else begin
            $display("store strobe %s at time %0t in test %0d",
                     exp_store[c] ? "missing" : "seen but not expected", $time, t);
            count_error(t);
        end
        assert (last === exp_last[c]) else begin
            $display("last strobe %s at time %0t in test %0d",
                     exp_last[c] ? "missing" : "seen but not expected", $time, t);
            count_error(t);
        end
        if (exp_store[c]) begin
            assert (core_result === exp_val[c]) else begin
                $display("mismatch at time %0t: test %0d stored %h, model %h (low words)",
                         $time, t, core_result[31:0], exp_val[c][31:0]);
                count_error(t);
            end
        end else begin
            assert (core_result === '0) else begin
                $display("mismatch at time %0t: test %0d core_result not zero without store",
                         $time, t);
                count_error(t);
            end
        end
    endtask

    // a test is done once the checks of its last step have run
    task automatic report_finished(input int c);
        int k;
        int t;
        k = c - 2;
        if (k >= 0) begin
            t = int'(prog[k][23:20]);
            if (k == n_steps - 1 || int'(prog[k + 1][23:20]) != t) begin
                if (test_errs[t] == 0) begin
                    tests_passed++;
                    $display("test %0d passed", t);
                end else begin
                    tests_failed++;
                    $display("test %0d failed with %0d errors", t, test_errs[t]);
                end
            end
        end
    endtask

    task automatic drive_entry(input int c);
        logic [3:0] kind;
        kind = (c < n_steps) ? prog[c][19:16] : k_idle;
        // exec follows every instruction by one cycle
        exec        = (c > 0 && c <= n_steps) ? (prog[c - 1][19:16] == k_inst) : 1'b0;
        get_v       = (kind == k_inst);
        get_d       = (kind == k_inst) ? prog[c][15:0] : '0;
        gen         = (kind == k_gen);
        update_item = (kind == k_gen);
        item_a      = (kind == k_gen) ? prog[c][9:0] : '0;
        run         = (kind != k_drop);
    endtask

    initial begin
        arst_n      = 1'b0;
        run         = 1'b0;
        gen         = 1'b0;
        update_item = 1'b0;
        item_a      = '0;
        get_v       = 1'b0;
        get_d       = '0;
        exec        = 1'b0;
        m_lfsr      = {(dim / 32){`HDC_LFSR_SEED}};
        m_reg_1     = '0;
        m_reg_2     = '0;
        m_buff      = '0;
        m_cnt       = '{default: 0};
        test_errs   = '{default: 0};
        for (int k = 0; k < n_steps + 2; k++) begin
            exp_val[k] = '0;
        end
        for (int k = 0; k < n_steps; k++) begin
            model_step(k);
        end
        // run stays low during reset so the alu registers clear too
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        run    = 1'b1;
        for (int c = 0; c < n_steps + 2; c++) begin
            @(negedge clk);
            check_outputs(c);
            report_finished(c);
            drive_entry(c);
        end
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, total_errs);
        if (total_errs == 0 && tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+source
source/hdc_data_pkg.sv
source/hdc_isa_pkg.sv
source/hdc_item_memory.sv
source/hdc_item_lfsr.sv
source/hdc_inst_decode.sv
source/hdc_vector_alu.sv
source/hdc_bundler.sv
source/hdc_accel_top.sv
tb/hdc_accel_tb.sv

// ==== build.sh ====
#!/usr/bin/env bash
# compile and run the hdc accelerator testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module hdc_accel_tb -f all.f -o hdc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/hdc_sim)"
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$sim_out"; then
    exit 0
fi
exit 1
